//--- Bender.yml
package:
  name: hazard_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/hazPkg.sv
      - verilog/instrDecode.sv
      - verilog/stageTracker.sv
      - verilog/hazardCheck.sv
      - verilog/stallControl.sv
      - verilog/hazardUnit.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/hazardUnitTb.sv

//--- all.f
+incdir+include
verilog/hazPkg.sv
verilog/instrDecode.sv
verilog/stageTracker.sv
verilog/hazardCheck.sv
verilog/stallControl.sv
verilog/hazardUnit.sv
bench/hazardUnitTb.sv

//--- bench/hazardCases.txt
# instr rd writes memEnable reg1Data | expected nop pcStall forwards
# forwards bits: exToExRs memToExRs exToExRt memToExRt exToIdRs memToIdRs
# Independent sequence after reset
c5c4 1 1 0 0000 0 0 00
c5e8 2 1 0 0000 0 0 00
4661 3 1 0 0000 0 0 00
c7d0 4 1 0 0000 0 0 00
# Register dependence, distances 1 to 4, rt ignored for addi
c474 5 1 0 0000 0 0 24
c4b8 6 1 0 0000 0 0 18
40c5 6 1 0 0000 0 0 00
c504 1 1 0 0000 1 1 00
c504 1 1 0 0000 1 1 00
c504 1 1 0 0000 0 0 00
# Load followed by a dependent add
8f42 2 1 1 0100 0 0 00
c20c 3 1 0 0000 1 1 00
c20c 3 1 0 0000 0 0 10
# Indirect jumps, early paths and a stall behind a load
c6f0 4 1 0 0000 0 0 00
2b00 0 0 0 0000 0 0 12
c6f4 5 1 0 0000 1 0 00
3c00 7 1 0 0000 0 0 01
40c1 6 1 0 0000 1 0 00
8e20 1 1 1 0200 0 0 00
2900 0 0 0 0000 1 1 00
2900 0 0 0 0000 0 0 10
c6e8 2 1 0 0000 1 0 00
# Memory address hazards, negative offset hits the earlier store
86e4 0 0 1 0300 0 0 00
4761 3 1 0 0000 0 0 00
8d9c 4 1 1 0308 1 1 00
8d9c 4 1 1 0308 1 1 00
8d9c 4 1 1 0308 1 1 00
8d9c 4 1 1 0308 0 0 00
8601 0 0 1 0400 0 0 00
8fa0 5 1 1 0402 0 0 00
# Jump and branch shadows
2000 0 0 0 0000 0 0 00
4022 1 1 0 0000 1 0 00
4043 2 1 0 0000 0 0 00
6204 0 0 0 0000 0 0 20
c6ec 3 1 0 0000 1 0 00
c6f0 4 1 0 0000 0 0 00
# Nop slot with aliased fields
0a00 0 0 0 0000 0 0 00
8fa0 5 1 1 0500 0 0 00
0d00 0 0 0 0000 0 0 00
c518 6 1 0 0000 0 0 10

//--- bench/hazardUnitTb.sv
`default_nettype none

module hazardUnitTb;
    import hazPkg::*;

    // One line of the cases file, stimulus first, then expected outputs
    typedef struct packed {
        instrWord_u instr;
        regIdx_t    rd;
        logic       writes;
        logic       memEnable;
        dataWord_t  reg1Data;
        logic       expNop;
        logic       expPcStall;
        fwd_t       expFwd;
    } caseRec_t;

    localparam string casesPath = "bench/hazardCases.txt";

    logic       clk;
    logic       arstN;
    instrWord_u instr;
    regIdx_t    rd;
    logic       writes;
    logic       memEnable;
    dataWord_t  reg1Data;
    logic       nop;
    logic       pcStall;
    fwd_t       forwards;

    caseRec_t cases[$];
    bit       casesLoaded;
    int       caseIdx;

    hazardUnit i_hazardUnit (
        .clk       (clk),
        .arstN     (arstN),
        .instr     (instr),
        .rd        (rd),
        .writes    (writes),
        .memEnable (memEnable),
        .reg1Data  (reg1Data),
        .nop       (nop),
        .pcStall   (pcStall),
        .forwards  (forwards)
    );

    always #2 clk = ~clk;

    task automatic abortRun();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [15:0] expected,
                                  input logic [15:0] actual);
        $display("ERROR: case %0d %s expected 0x%h actual 0x%h",
                 caseIdx, name, expected, actual);
        abortRun();
    endtask

    task automatic loadCases();
        int          fd;
        int          n;
        string       line;
        logic [15:0] vInstr;
        logic [15:0] vReg1;
        logic [7:0]  vRd;
        logic [7:0]  vWr;
        logic [7:0]  vMe;
        logic [7:0]  vNop;
        logic [7:0]  vStall;
        logic [7:0]  vFwd;
        caseRec_t    c;
        fd = $fopen(casesPath, "r");
        if (fd == 0) begin
            $display("Could not open the cases file %s", casesPath);
            abortRun();
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
                break;
            end
            // Comment lines mark sections of the file
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                        vInstr, vRd, vWr, vMe, vReg1, vNop, vStall, vFwd);
            if (n <= 0) begin
                continue;
            end
            if (n != 8) begin
                $display("Cases file line has %0d fields instead of 8: %s", n, line);
                abortRun();
            end
            c.instr      = vInstr;
            c.rd         = vRd[2:0];
            c.writes     = vWr[0];
            c.memEnable  = vMe[0];
            c.reg1Data   = vReg1;
            c.expNop     = vNop[0];
            c.expPcStall = vStall[0];
            c.expFwd     = vFwd[5:0];
            cases.push_back(c);
        end
        $fclose(fd);
        if (cases.size() == 0) begin
            $display("The cases file holds no cases");
            abortRun();
        end
    endtask

    task automatic applyCase(input caseRec_t c);
        instr     = c.instr;
        rd        = c.rd;
        writes    = c.writes;
        memEnable = c.memEnable;
        reg1Data  = c.reg1Data;
    endtask

    task automatic checkOutputs(input caseRec_t c);
        assert (nop === c.expNop)
            else reportMismatch("nop", c.expNop, nop);
        assert (pcStall === c.expPcStall)
            else reportMismatch("pcStall", c.expPcStall, pcStall);
        assert (forwards === c.expFwd)
            else reportMismatch("forwards", c.expFwd, forwards);
    endtask

    initial begin
        clk       = 1'b0;
        arstN     = 1'b0;
        instr     = 16'h0800;
        rd        = '0;
        writes    = 1'b0;
        memEnable = 1'b0;
        reg1Data  = '0;
        loadCases();
        casesLoaded = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        arstN = 1'b1;
        // Drive just after the edge, sample just before the next one
        for (caseIdx = 0; caseIdx < cases.size(); caseIdx++) begin
            applyCase(cases[caseIdx]);
            #2;
            checkOutputs(cases[caseIdx]);
            @(posedge clk);
            #1;
        end
        $display("All checks passed");
        $finish;
    end

    // Watchdog sized from the number of cases
    initial begin
        int limit;
        wait (casesLoaded);
        limit = 2 * cases.size() * 4 + 100;
        #(limit);
        $display("Timeout, the run did not finish within %0d time units", limit);
        abortRun();
    end

endmodule

`default_nettype wire

//--- include/hazDet_defines.svh
`ifndef HAZDET_DEFINES_SVH
`define HAZDET_DEFINES_SVH

// Word and register index widths fixed by the instruction set
`define HAZ_INSTR_W 16
`define HAZ_REG_W 3

// Tracked pipeline stages ahead of the fetch slot: ID, EX, MEM, WB
`define HAZ_STAGES 4

// Full 5-bit opcodes
`define HAZ_OPC_NOP  5'b00001
`define HAZ_OPC_JR   5'b00101
`define HAZ_OPC_JALR 5'b00111
`define HAZ_OPC_ST   5'b10000

// Opcode classes in the top three opcode bits
`define HAZ_CLS_JUMP   3'b001
`define HAZ_CLS_BRANCH 3'b011
`define HAZ_CLS_ALU_R  3'b110

`endif

//--- verilog/hazPkg.sv
`default_nettype none

`include "hazDet_defines.svh"

package hazPkg;

    localparam int numStages = `HAZ_STAGES;

    typedef logic [`HAZ_REG_W-1:0]   regIdx_t;
    typedef logic [`HAZ_INSTR_W-1:0] dataWord_t;

    // Register-register layout of the instruction word
    typedef struct packed {
        logic [4:0] opcode;
        regIdx_t    rs;
        regIdx_t    rt;
        regIdx_t    rd;
        logic [1:0] funct;
    } instrRegForm_t;

    // Immediate layout, same opcode and rs position
    typedef struct packed {
        logic [4:0] opcode;
        regIdx_t    rs;
        regIdx_t    rd;
        logic [4:0] imm5;
    } instrImmForm_t;

    typedef union packed {
        instrRegForm_t r;
        instrImmForm_t i;
    } instrWord_u;

    // What an issued instruction leaves behind in the history
    typedef struct packed {
        regIdx_t   rd;
        logic      writes;
        logic      memEn;
        dataWord_t memAddr;
    } issueRec_t;

    typedef issueRec_t stageRec_t;

    // Index 0 is ID, the last index is WB
    typedef stageRec_t stageArr_t [numStages];

    // Bit order matches the forwarding bus of the datapath, MSB first
    typedef struct packed {
        logic exToExRs;
        logic memToExRs;
        logic exToExRt;
        logic memToExRt;
        logic exToIdRs;
        logic memToIdRs;
    } fwd_t;

    typedef struct packed {
        regIdx_t   rs;
        regIdx_t   rt;
        logic      readsRt;
        logic      isIndirect;
        logic      isJumpBranch;
        logic      isNop;
        logic      memEn;
        dataWord_t memAddr;
    } slotInfo_t;

endpackage

`default_nettype wire

//--- verilog/hazardCheck.sv
`default_nettype none

module hazardCheck (
    input  hazPkg::slotInfo_t slot,
    input  hazPkg::stageArr_t stages,
    output hazPkg::fwd_t      forwards,
    output logic              regHaz,
    output logic              memHaz
);
    import hazPkg::*;

    localparam int stId  = 0;
    localparam int stEx  = 1;
    localparam int stMem = 2;
    localparam int stWb  = 3;

    // One bit per tracked stage with bit 0 for ID
    logic [numStages-1:0] matchRs;
    logic [numStages-1:0] matchRt;
    logic [numStages-1:0] addrHit;
    logic [numStages-1:0] coverRs;
    logic [numStages-1:0] coverRt;
    logic                 rsHaz;
    logic                 rtHaz;
    logic                 loadUse;

    always_comb begin
        for (int s = 0; s < numStages; s++) begin
            matchRs[s] = stages[s].writes && (stages[s].rd == slot.rs);
            // rt field is junk for forms that do not read it
            matchRt[s] = stages[s].writes && (stages[s].rd == slot.rt) && slot.readsRt;
            addrHit[s] = stages[s].memEn && (stages[s].memAddr == slot.memAddr);
        end
    end

    always_comb begin
        forwards = '0;

        // ALU result from the instruction one ahead unless it is a load
        forwards.exToExRs = matchRs[stId] && !stages[stId].memEn;
        forwards.exToExRt = matchRt[stId] && !stages[stId].memEn;

        // Value from two ahead is ready at the end of MEM whatever produced it
        forwards.memToExRs = matchRs[stEx];
        forwards.memToExRt = matchRt[stEx];

        // Early paths so an indirect jump has its target in ID
        forwards.exToIdRs  = matchRs[stEx] && !stages[stEx].memEn && slot.isIndirect;
        forwards.memToIdRs = matchRs[stMem] && slot.isIndirect;
    end

    // Which stage matches some forward already resolves
    always_comb begin
        coverRs        = '0;
        coverRs[stId]  = forwards.exToExRs;
        coverRs[stEx]  = forwards.memToExRs || forwards.exToIdRs;
        coverRs[stMem] = forwards.memToIdRs;

        coverRt       = '0;
        coverRt[stId] = forwards.exToExRt;
        coverRt[stEx] = forwards.memToExRt;
    end

    assign rsHaz = |(matchRs & ~coverRs);
    assign rtHaz = |(matchRt & ~coverRt);

    // Load data is not there yet for the next instruction
    assign loadUse = (matchRs[stId] || matchRt[stId]) && stages[stId].memEn;

    assign regHaz = rsHaz || rtHaz || loadUse;

    // Keep memory accesses to one address in order
    assign memHaz = slot.memEn && (|addrHit);

    // ID and EX paths together fully cover rs when no older stage produces it
    always_comb begin
        assert final (!((forwards.exToExRs && forwards.memToExRs) &&
                        !matchRs[stMem] && !matchRs[stWb] && rsHaz))
            else $error("hazardCheck: rs forwarded from ID and EX but still stalls");
    end

endmodule

`default_nettype wire

//--- verilog/hazardUnit.sv
`default_nettype none

module hazardUnit (
    input  logic               clk,
    input  logic               arstN,
    input  hazPkg::instrWord_u instr,
    input  hazPkg::regIdx_t    rd,
    input  logic               writes,
    input  logic               memEnable,
    input  hazPkg::dataWord_t  reg1Data,
    output logic               nop,
    output logic               pcStall,
    output hazPkg::fwd_t       forwards
);
    import hazPkg::*;

    slotInfo_t slot;
    issueRec_t issue;
    stageArr_t stages;
    logic      regHaz;
    logic      memHaz;

    // Record of the instruction leaving the fetch slot this cycle
    assign issue = '{rd: rd, writes: writes, memEn: memEnable, memAddr: slot.memAddr};

    instrDecode i_instrDecode (
        .instr     (instr),
        .reg1Data  (reg1Data),
        .memEnable (memEnable),
        .slot      (slot)
    );

    stageTracker i_stageTracker (
        .clk    (clk),
        .arstN  (arstN),
        .issue  (issue),
        .bubble (nop),
        .stages (stages)
    );

    hazardCheck i_hazardCheck (
        .slot     (slot),
        .stages   (stages),
        .forwards (forwards),
        .regHaz   (regHaz),
        .memHaz   (memHaz)
    );

    stallControl i_stallControl (
        .clk     (clk),
        .arstN   (arstN),
        .slot    (slot),
        .regHaz  (regHaz),
        .memHaz  (memHaz),
        .nop     (nop),
        .pcStall (pcStall)
    );

endmodule

`default_nettype wire

//--- verilog/instrDecode.sv
`default_nettype none

`include "hazDet_defines.svh"

module instrDecode (
    input  hazPkg::instrWord_u      instr,
    input  logic [`HAZ_INSTR_W-1:0] reg1Data,
    input  logic                    memEnable,
    output hazPkg::slotInfo_t       slot
);
    import hazPkg::*;

    logic [4:0]              opcode;
    logic [2:0]              opClass;
    logic [`HAZ_INSTR_W-1:0] immExt;

    assign opcode  = instr.r.opcode;
    assign opClass = opcode[4:2];

    // Offset is signed, so a negative imm5 walks below the base
    assign immExt = {{(`HAZ_INSTR_W - 5){instr.i.imm5[4]}}, instr.i.imm5};

    always_comb begin
        slot = '0;

        // Source fields sit at the same bits in both forms
        slot.rs = instr.r.rs;
        slot.rt = instr.r.rt;

        // Only register-register ALU ops and stores read rt
        slot.readsRt = (opClass == `HAZ_CLS_ALU_R) || (opcode == `HAZ_OPC_ST);

        // JR and JALR need rs already in ID for the target
        slot.isIndirect = (opcode == `HAZ_OPC_JR) || (opcode == `HAZ_OPC_JALR);

        slot.isJumpBranch = (opClass == `HAZ_CLS_JUMP) || (opClass == `HAZ_CLS_BRANCH);
        slot.isNop        = (opcode == `HAZ_OPC_NOP);

        slot.memEn   = memEnable;
        slot.memAddr = reg1Data + immExt;
    end

    // A squashed slot must never also start a branch shadow
    always_comb begin
        assert final (!(slot.isNop && slot.isJumpBranch))
            else $error("instrDecode: opcode %b decoded as both nop and jump", opcode);
    end

endmodule

`default_nettype wire

//--- verilog/stageTracker.sv
`default_nettype none

`include "hazDet_defines.svh"

module stageTracker (
    input  logic              clk,
    input  logic              arstN,
    input  hazPkg::issueRec_t issue,
    input  logic              bubble,
    output hazPkg::stageArr_t stages
);
    import hazPkg::*;

    // History moves one stage per cycle whether stalled or not
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int s = 0; s < `HAZ_STAGES; s++) begin
                stages[s] <= '0;
            end
        end else begin
            // A held instruction is not issued and an empty record enters instead
            if (bubble) begin
                stages[0] <= '0;
            end else begin
                stages[0] <= issue;
            end
            for (int s = 1; s < `HAZ_STAGES; s++) begin
                stages[s] <= stages[s-1];
            end
        end
    end

    // Bubble must not look like a producer or a memory access in ID
    assert property (@(posedge clk) disable iff (!arstN)
        bubble |=> (!stages[0].writes && !stages[0].memEn))
        else $error("stageTracker: bubble entered ID with writes or memEn set");

    // Address compares downstream are only meaningful with a known address
    for (genvar g = 0; g < `HAZ_STAGES; g++) begin : gAddrKnown
        assert property (@(posedge clk) disable iff (!arstN)
            stages[g].memEn |-> !$isunknown(stages[g].memAddr))
            else $error("stageTracker: stage %0d has memEn with unknown address", g);
    end

endmodule

`default_nettype wire

//--- verilog/stallControl.sv
`default_nettype none

module stallControl (
    input  logic              clk,
    input  logic              arstN,
    input  hazPkg::slotInfo_t slot,
    input  logic              regHaz,
    input  logic              memHaz,
    output logic              nop,
    output logic              pcStall
);
    import hazPkg::*;

    // Set for one cycle after a jump or branch leaves the fetch slot
    logic shadowQ;

    // A nop slot has no real operands and its fields can alias anything
    assign pcStall = (regHaz || memHaz) && !slot.isNop;
    assign nop     = (pcStall || shadowQ) && !slot.isNop;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            shadowQ <= 1'b0;
        end else begin
            // A held jump has not issued yet and casts no shadow
            shadowQ <= slot.isJumpBranch && !pcStall;
        end
    end

    assert property (@(posedge clk) disable iff (!arstN)
        pcStall |-> nop)
        else $error("stallControl: pcStall without nop");

endmodule

`default_nettype wire
